// ==== logic/aes_params.svh ====
// ====================================================================
// Global constants for the AES panel design
// Included by the packages and by the RTL that needs the limits
// ====================================================================
`ifndef AES_PARAMS_SVH
`define AES_PARAMS_SVH

// Cipher geometry for AES-128
`define AES_ROUNDS 10
`define AES_BLOCK_BITS 128

// Panel limits
`define PHASE_COUNT 16
`define BYTE_MAX 255
`define BYTE_MIN 0

`endif

// ==== logic/aesPkg.sv ====
// ====================================================================
// Cipher types and byte-level helpers shared by the AES datapath
// and the key schedule
// ====================================================================
`include "aes_params.svh"

package aesPkg;

	localparam int BLOCK_BYTES = `AES_BLOCK_BITS / 8;
	localparam int BLOCK_COLS = BLOCK_BYTES / 4;

	typedef logic [7:0] aesByteT;
	typedef logic [31:0] aesWordT;

	// Round index, 0 to 10
	typedef logic [3:0] roundNumT;

	// One block seen as FIPS-197 bytes or as state columns
	// Byte 0 and column 0 sit in the top bits
	typedef union packed {
		aesByteT [0:BLOCK_BYTES-1] bytes;
		aesWordT [0:BLOCK_COLS-1] cols;
	} aesBlockT;

	// ================================================================
	// Forward S-box
	// ================================================================

	// Entry 0 first, 32 entries per line
	localparam logic [2047:0] SBOX_TABLE = {
		256'h637c777bf26b6fc53001672bfed7ab76_ca82c97dfa5947f0add4a2af9ca472c0,
		256'hb7fd9326363ff7cc34a5e5f171d83115_04c723c31896059a071280e2eb27b275,
		256'h09832c1a1b6e5aa0523bd6b329e32f84_53d100ed20fcb15b6acbbe394a4c58cf,
		256'hd0efaafb434d338545f9027f503c9fa8_51a3408f929d38f5bcb6da2110fff3d2,
		256'hcd0c13ec5f974417c4a77e3d645d1973_60814fdc222a908846eeb814de5e0bdb,
		256'he0323a0a4906245cc2d3ac629195e479_e7c8376d8dd54ea96c56f4ea657aae08,
		256'hba78252e1ca6b4c6e8dd741f4bbd8b8a_703eb5664803f60e613557b986c11d9e,
		256'he1f8981169d98e949b1e87e9ce5528df_8ca1890dbfe6426841992d0fb054bb16
	};

	function automatic aesByteT sbox(input aesByteT in);
		return SBOX_TABLE[(255 - int'(in)) * 8 +: 8];
	endfunction

	// ================================================================
	// GF(2^8) arithmetic
	// ================================================================

	// Multiply by 2, reduced by the AES polynomial
	function automatic aesByteT xtime(input aesByteT in);
		aesByteT shifted;
		shifted = {in[6:0], 1'b0};
		return in[7] ? (shifted ^ 8'h1b) : shifted;
	endfunction

endpackage

// ==== logic/panelPkg.sv ====
// ====================================================================
// Types for the button panel and its byte display
// ====================================================================
`include "aes_params.svh"

package panelPkg;

	// Phase k selects AES byte 15-k, so phase 0 is the last block byte
	typedef logic [$clog2(`PHASE_COUNT)-1:0] phaseT;

	// Byte shown on the display
	typedef logic [7:0] displayT;

endpackage

// ==== logic/roundBusIf.sv ====
// ====================================================================
// Round control and round key shared by the FSM, the round counter,
// the key schedule and the datapath
// ====================================================================
`timescale 1ns/1ps

interface roundBusIf;
	import aesPkg::*;

	// One-cycle strobes from the FSM, never high together
	logic     load;
	logic     step;

	roundNumT roundNum;
	aesBlockT roundKey;

	modport ctrl (output load, output step);
	modport counter (input load, input step, output roundNum);
	modport keys (input load, input step, input roundNum, output roundKey);
	modport datapath (input load, input step, input roundNum, input roundKey);

endinterface

// ==== logic/encryptCtrl.sv ====
// ====================================================================
// Encryption FSM: starts a run when set falls, steps the rounds
// and holds cipherValid until set rises again
// ====================================================================
`timescale 1ns/1ps

module encryptCtrl (
	input  logic    clk,
	input  logic    rstN,
	input  logic    set,
	input  logic    roundsDone,
	output logic    cipherValid,
	roundBusIf.ctrl bus
);

	typedef enum logic [1:0] {
		IDLE,
		LOAD,
		RUN,
		DONE
	} stateT;

	stateT state;
	stateT nextState;
	logic  setQ;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= IDLE;
			setQ  <= 1'b0;
		end else begin
			state <= nextState;
			setQ  <= set;
		end
	end

	always_comb begin
		nextState = state;
		case (state)
			RUN:     if (roundsDone) nextState = DONE;
			DONE:    if (set) nextState = IDLE;
			LOAD:    nextState = RUN;
			default: nextState = state;
		endcase
		// A fresh falling edge of set restarts from any state
		if (setQ && !set) begin
			nextState = LOAD;
		end
	end

	assign bus.load = (state == LOAD);
	// No step in the cycle that carries roundsDone
	assign bus.step = (state == RUN) && !roundsDone;
	assign cipherValid = (state == DONE);

endmodule

// ==== logic/roundCounter.sv ====
// ====================================================================
// Round number for the key schedule and datapath, with a pulse once
// the final round has been applied
// ====================================================================
`timescale 1ns/1ps
`include "aes_params.svh"

module roundCounter (
	input  logic       clk,
	input  logic       rstN,
	output logic       roundsDone,
	roundBusIf.counter bus
);
	import aesPkg::*;

	logic lastRound;

	assign lastRound = (bus.roundNum == roundNumT'(`AES_ROUNDS));

	always_ff @(posedge clk) begin
		if (!rstN) begin
			bus.roundNum <= '0;
			roundsDone   <= 1'b0;
		end else begin
			roundsDone <= bus.step && lastRound;
			if (bus.load) begin
				bus.roundNum <= roundNumT'(1);
			end else if (bus.step && !lastRound) begin
				bus.roundNum <= bus.roundNum + roundNumT'(1);
			end
		end
	end

endmodule

// ==== logic/keySchedule.sv ====
// ====================================================================
// AES-128 key expansion, one round key per step
// Drives the cipher key during load and the next expanded key after
// ====================================================================
`timescale 1ns/1ps

module keySchedule (
	input  logic             clk,
	input  logic             rstN,
	input  aesPkg::aesBlockT cipherKey,
	roundBusIf.keys          bus
);
	import aesPkg::*;

	aesBlockT keyReg;
	aesBlockT nextKey;
	aesWordT  rotSub;
	aesByteT  rcon;

	// Round constants 1 to 10
	always_comb begin
		case (bus.roundNum)
			4'd1:    rcon = 8'h01;
			4'd2:    rcon = 8'h02;
			4'd3:    rcon = 8'h04;
			4'd4:    rcon = 8'h08;
			4'd5:    rcon = 8'h10;
			4'd6:    rcon = 8'h20;
			4'd7:    rcon = 8'h40;
			4'd8:    rcon = 8'h80;
			4'd9:    rcon = 8'h1b;
			4'd10:   rcon = 8'h36;
			default: rcon = 8'h00;
		endcase
	end

	always_comb begin
		// RotWord then SubWord on the last column
		rotSub = {sbox(keyReg.cols[3][23:16]), sbox(keyReg.cols[3][15:8]),
			sbox(keyReg.cols[3][7:0]), sbox(keyReg.cols[3][31:24])};
		nextKey.cols[0] = keyReg.cols[0] ^ rotSub ^ {rcon, 24'h000000};
		for (int c = 1; c < BLOCK_COLS; c++) begin
			nextKey.cols[c] = keyReg.cols[c] ^ nextKey.cols[c-1];
		end
	end

	assign bus.roundKey = bus.load ? cipherKey : nextKey;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			keyReg <= '0;
		end else if (bus.load) begin
			keyReg <= cipherKey;
		end else if (bus.step) begin
			keyReg <= nextKey;
		end
	end

endmodule

// ==== logic/roundDatapath.sv ====
// ====================================================================
// AES state register with one full round applied per step
// The final round leaves out MixColumns
// ====================================================================
`timescale 1ns/1ps
`include "aes_params.svh"

module roundDatapath (
	input  logic             clk,
	input  logic             rstN,
	input  aesPkg::aesBlockT plainBlock,
	output aesPkg::aesBlockT cipherBlock,
	roundBusIf.datapath      bus
);
	import aesPkg::*;

	aesBlockT stateReg;
	aesBlockT subShift;
	aesBlockT mixed;
	aesBlockT roundOut;
	logic     finalRound;

	// One state column times the fixed MixColumns matrix
	function automatic aesWordT mixColumn(input aesWordT col);
		aesByteT a0;
		aesByteT a1;
		aesByteT a2;
		aesByteT a3;
		a0 = col[31:24];
		a1 = col[23:16];
		a2 = col[15:8];
		a3 = col[7:0];
		return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
			a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
			a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
			xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
	endfunction

	// ================================================================
	// Round logic
	// ================================================================

	// SubBytes and ShiftRows, row r rotates left by r columns
	always_comb begin
		for (int c = 0; c < BLOCK_COLS; c++) begin
			for (int r = 0; r < 4; r++) begin
				subShift.bytes[r + 4 * c] = sbox(stateReg.bytes[r + 4 * ((c + r) % 4)]);
			end
		end
	end

	always_comb begin
		for (int c = 0; c < BLOCK_COLS; c++) begin
			mixed.cols[c] = mixColumn(subShift.cols[c]);
		end
	end

	assign finalRound = (bus.roundNum == roundNumT'(`AES_ROUNDS));
	assign roundOut = (finalRound ? subShift : mixed) ^ bus.roundKey;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			stateReg <= '0;
		end else if (bus.load) begin
			// Initial AddRoundKey
			stateReg <= plainBlock ^ bus.roundKey;
		end else if (bus.step) begin
			stateReg <= roundOut;
		end
	end

	assign cipherBlock = stateReg;

endmodule

// ==== logic/panelEntry.sv ====
// ====================================================================
// Button panel: phase selection, plaintext byte entry and the
// registered display byte
// ====================================================================
`timescale 1ns/1ps
`include "aes_params.svh"

module panelEntry (
	input  logic              clk,
	input  logic              rstN,
	input  logic              set,
	input  logic              buttonU,
	input  logic              buttonD,
	input  logic              buttonL,
	input  logic              buttonR,
	input  logic              cipherValid,
	input  aesPkg::aesBlockT  cipherBlock,
	output aesPkg::aesBlockT  plainBlock,
	output panelPkg::phaseT   curPhase,
	output panelPkg::displayT sevenNum
);
	import aesPkg::*;
	import panelPkg::*;

	phaseT   byteIdx;
	aesByteT plainSel;
	aesByteT cipherSel;

	// Phase k maps onto block byte 15-k
	assign byteIdx   = phaseT'(`PHASE_COUNT - 1) - curPhase;
	assign plainSel  = plainBlock.bytes[byteIdx];
	assign cipherSel = cipherBlock.bytes[byteIdx];

	// Phase wraps both ways, R has priority
	always_ff @(posedge clk) begin
		if (!rstN) begin
			curPhase <= '0;
		end else if (buttonR) begin
			curPhase <= curPhase + phaseT'(1);
		end else if (buttonL) begin
			curPhase <= curPhase - phaseT'(1);
		end
	end

	// Byte entry only in set mode, saturating at both ends
	always_ff @(posedge clk) begin
		if (!rstN) begin
			plainBlock <= '0;
		end else if (set) begin
			if (buttonU) begin
				if (plainSel != aesByteT'(`BYTE_MAX)) begin
					plainBlock.bytes[byteIdx] <= plainSel + 8'd1;
				end
			end else if (buttonD) begin
				if (plainSel != aesByteT'(`BYTE_MIN)) begin
					plainBlock.bytes[byteIdx] <= plainSel - 8'd1;
				end
			end
		end
	end

	// Plaintext while editing, ciphertext once valid, blank otherwise
	always_ff @(posedge clk) begin
		if (!rstN) begin
			sevenNum <= '0;
		end else if (set) begin
			sevenNum <= plainSel;
		end else if (cipherValid) begin
			sevenNum <= cipherSel;
		end else begin
			sevenNum <= '0;
		end
	end

endmodule

// ==== logic/aesPanelTop.sv ====
// ====================================================================
// Top level of the AES-128 button panel encryptor
// Connects the FSM, round counter, key schedule, datapath and panel
// ====================================================================
`timescale 1ns/1ps

module aesPanelTop (
	input  logic              clk,
	input  logic              rstN,
	input  logic              set,
	input  logic              buttonU,
	input  logic              buttonD,
	input  logic              buttonL,
	input  logic              buttonR,
	input  aesPkg::aesBlockT  cipherKey,
	output panelPkg::phaseT   curPhase,
	output panelPkg::displayT sevenNum,
	output logic              cipherValid
);
	import aesPkg::*;

	aesBlockT plainBlock;
	aesBlockT cipherBlock;
	logic     roundsDone;

	roundBusIf bus ();

	// ================================================================
	// Cipher core
	// ================================================================

	encryptCtrl uCtrl (
		.clk(clk),
		.rstN(rstN),
		.set(set),
		.roundsDone(roundsDone),
		.cipherValid(cipherValid),
		.bus(bus.ctrl)
	);

	roundCounter uCounter (
		.clk(clk),
		.rstN(rstN),
		.roundsDone(roundsDone),
		.bus(bus.counter)
	);

	keySchedule uKeys (
		.clk(clk),
		.rstN(rstN),
		.cipherKey(cipherKey),
		.bus(bus.keys)
	);

	roundDatapath uDatapath (
		.clk(clk),
		.rstN(rstN),
		.plainBlock(plainBlock),
		.cipherBlock(cipherBlock),
		.bus(bus.datapath)
	);

	// ================================================================
	// Panel
	// ================================================================

	panelEntry uPanel (
		.clk(clk),
		.rstN(rstN),
		.set(set),
		.buttonU(buttonU),
		.buttonD(buttonD),
		.buttonL(buttonL),
		.buttonR(buttonR),
		.cipherValid(cipherValid),
		.cipherBlock(cipherBlock),
		.plainBlock(plainBlock),
		.curPhase(curPhase),
		.sevenNum(sevenNum)
	);

endmodule

// ==== test/aesPanelTb.sv ====
// ====================================================================
// Self-checking testbench for the AES panel encryptor
// Enters each plaintext from test/aes_vectors.txt and reads back the cipher
// ====================================================================
`timescale 1ns/1ps
`include "aes_params.svh"

module aesPanelTb;
	import aesPkg::*;
	import panelPkg::*;

	localparam int NUM_VECTORS = 3;
	localparam int CYCLE_LIMIT = NUM_VECTORS * (16 * 260 + 64) + 1000;

	logic     clk;
	logic     rstN;
	logic     set;
	logic     buttonU;
	logic     buttonD;
	logic     buttonL;
	logic     buttonR;
	aesBlockT cipherKey;
	phaseT    curPhase;
	displayT  sevenNum;
	logic     cipherValid;

	// Key, plaintext, ciphertext per vector
	logic [127:0] vecMem [0:3*NUM_VECTORS-1];
	displayT      plainModel [0:`PHASE_COUNT-1];
	phaseT        phaseModel;
	int           cycleCount = 0;

	aesPanelTop dut (
		.clk(clk),
		.rstN(rstN),
		.set(set),
		.buttonU(buttonU),
		.buttonD(buttonD),
		.buttonL(buttonL),
		.buttonR(buttonR),
		.cipherKey(cipherKey),
		.curPhase(curPhase),
		.sevenNum(sevenNum),
		.cipherValid(cipherValid)
	);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycleCount = cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Verification failed");
			$fatal(1, "Run stopped by the cycle limit");
		end
	end

	// ================================================================
	// Checks
	// ================================================================

	task automatic stopOnError();
		$display("Verification failed");
		$fatal(1, "Run stopped at the first failing check");
	endtask

	task automatic checkPhase(input string name, input phaseT expected);
		if (curPhase !== expected) begin
			$display("** Error %s: expected phase %0d, actual %0d", name, expected, curPhase);
			stopOnError();
		end
	endtask

	task automatic checkDisplay(input string name, input displayT expected);
		if (sevenNum !== expected) begin
			$display("** Error %s: expected display %h, actual %h", name, expected, sevenNum);
			stopOnError();
		end
	endtask

	task automatic checkValid(input string name, input bit expected);
		if (cipherValid !== expected) begin
			$display("** Error %s: expected cipherValid %0b, actual %0b",
				name, expected, cipherValid);
			stopOnError();
		end
	endtask

	// ================================================================
	// Stimulus helpers
	// ================================================================

	// Step to 2 ns past the next rising edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	function automatic bit randomBit();
		return 1'($urandom % 2);
	endfunction

	task automatic driveButtons(input logic u, input logic d, input logic l, input logic r);
		buttonU = u;
		buttonD = d;
		buttonL = l;
		buttonR = r;
	endtask

	// One-cycle button pulse
	task automatic press(input logic u, input logic d, input logic l, input logic r);
		driveButtons(u, d, l, r);
		nextCycle();
		driveButtons(1'b0, 1'b0, 1'b0, 1'b0);
	endtask

	// Saturating byte model
	function automatic displayT stepByte(input displayT value, input bit up);
		if (up) begin
			if (value == displayT'(`BYTE_MAX)) return value;
			return value + 8'd1;
		end
		if (value == displayT'(`BYTE_MIN)) return value;
		return value - 8'd1;
	endfunction

	task automatic pressEdit(input bit up);
		press(up, !up, 1'b0, 1'b0);
		plainModel[phaseModel] = stepByte(plainModel[phaseModel], up);
	endtask

	// Phase moves modulo 16, R before L
	task automatic stepPhase(input logic l, input logic r, input string name);
		press(1'b0, 1'b0, l, r);
		if (r) begin
			phaseModel = phaseT'((int'(phaseModel) + 1) % `PHASE_COUNT);
		end else if (l) begin
			phaseModel = phaseT'((int'(phaseModel) + `PHASE_COUNT - 1) % `PHASE_COUNT);
		end
		checkPhase(name, phaseModel);
	endtask

	// Clear the byte, count up to target, then disturb and restore it
	task automatic enterByte(input displayT target);
		int extra;
		bit up;
		while (plainModel[phaseModel] != 8'd0) pressEdit(1'b0);
		repeat (target) pressEdit(1'b1);
		extra = 1 + int'($urandom % 4);
		for (int i = 0; i < extra; i++) begin
			up = randomBit();
			// Push into saturation at both ends
			if (i == 0 && target == displayT'(`BYTE_MIN)) up = 1'b0;
			if (i == 0 && target == displayT'(`BYTE_MAX)) up = 1'b1;
			pressEdit(up);
		end
		nextCycle();
		checkDisplay("byte entry with extra presses", plainModel[phaseModel]);
		while (plainModel[phaseModel] != target) pressEdit(plainModel[phaseModel] < target);
		nextCycle();
		checkDisplay("byte entry", target);
	endtask

	// ================================================================
	// One vector: entry, encryption, readout, back to entry
	// ================================================================

	// Phase k is AES byte 15-k, so it sits at bits 8k+7:8k
	task automatic runVector(input int v);
		logic [127:0] plainVec;
		logic [127:0] cipherVec;
		plainVec = vecMem[3*v+1];
		cipherVec = vecMem[3*v+2];
		cipherKey = vecMem[3*v];
		set = 1'b1;
		nextCycle();
		for (int k = 0; k < `PHASE_COUNT; k++) begin
			enterByte(plainVec[8*k +: 8]);
			stepPhase(1'b0, 1'b1, "phase advance during entry");
		end

		// Edge 0 is the start edge where set is first sampled low
		set = 1'b0;
		for (int e = 0; e <= 12; e++) begin
			driveButtons(randomBit(), randomBit(), 1'b0, 1'b0);
			nextCycle();
			checkValid("cipherValid timing", bit'(e == 12));
			checkDisplay("blank display during encryption", 8'd0);
		end

		for (int k = 0; k < `PHASE_COUNT; k++) begin
			driveButtons(randomBit(), randomBit(), 1'b0, 1'b0);
			nextCycle();
			checkDisplay("ciphertext byte", cipherVec[8*k +: 8]);
			stepPhase(1'b0, 1'b1, "phase advance during readout");
		end

		// Back to entry with the plaintext untouched by the presses above
		set = 1'b1;
		nextCycle();
		checkValid("cipherValid after set rises", 1'b0);
		checkDisplay("plaintext after set rises", plainVec[7:0]);
		for (int k = 1; k < `PHASE_COUNT; k++) begin
			stepPhase(1'b0, 1'b1, "phase advance in plaintext review");
			nextCycle();
			checkDisplay("plaintext after set rises", plainVec[8*k +: 8]);
		end
		stepPhase(1'b0, 1'b1, "phase wrap in plaintext review");
	endtask

	initial begin
		void'($urandom(86672));
		rstN = 1'b0;
		set = 1'b0;
		cipherKey = '0;
		driveButtons(1'b0, 1'b0, 1'b0, 1'b0);
		$readmemh("test/aes_vectors.txt", vecMem);
		for (int i = 0; i < 3 * NUM_VECTORS; i++) begin
			if ($isunknown(vecMem[i])) begin
				$display("The vector file test/aes_vectors.txt is missing or incomplete");
				stopOnError();
			end
		end
		for (int k = 0; k < `PHASE_COUNT; k++) plainModel[k] = 8'd0;
		phaseModel = '0;

		repeat (10) nextCycle();
		rstN = 1'b1;
		nextCycle();
		checkPhase("reset", '0);
		checkDisplay("reset", 8'd0);
		checkValid("reset", 1'b0);

		// Wrap both ways, then both buttons together
		stepPhase(1'b1, 1'b0, "L at phase 0");
		stepPhase(1'b0, 1'b1, "R at phase 15");
		stepPhase(1'b1, 1'b1, "L and R together");
		stepPhase(1'b1, 1'b0, "L back to phase 0");

		for (int v = 0; v < NUM_VECTORS; v++) begin
			runVector(v);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

// ==== all.f ====
+incdir+logic
logic/aesPkg.sv
logic/panelPkg.sv
logic/roundBusIf.sv
logic/encryptCtrl.sv
logic/roundCounter.sv
logic/keySchedule.sv
logic/roundDatapath.sv
logic/panelEntry.sv
logic/aesPanelTop.sv
test/aesPanelTb.sv

// ==== Makefile ====
# Verilator build and run of the AES panel testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module aesPanelTb -f all.f -o VaesPanelTb
	./obj_dir/VaesPanelTb > sim.log 2>&1; cat sim.log
	grep -qx "Verification passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== test/aes_vectors.txt ====
// key plaintext ciphertext, 128-bit hex words, one vector per line
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
00000000000000000000000000000000 00000000000000000000000000000000 66e94bd4ef8a2c3b884cfa59ca342b2e
